//--- sim.f
+incdir+logic
logic/fpu_pkg.sv
logic/fpu_decoder.sv
logic/fpu_hold_buffer.sv
logic/fpu_exec_pipe.sv
logic/fpu_wrap.sv
bench/fpu_wrap_assert.sv
bench/tb_fpu_wrap.sv

//--- Makefile
# Verilator build and run of the FP32 unit testbench

SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
TOP      := tb_fpu_wrap
FILELIST := sim.f
OBJ_DIR  := obj_dir
LOG      := sim.log

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard logic/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "sim passed" $(LOG) || (echo "run did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/tb_fpu_wrap.sv
//----------------------------------------------------------------------
// Directed testbench of the scalar FP32 unit. Each test issues requests
// under the valid/ready handshake, a model predicts every result, and
// a monitor checks the results in issue order.
//----------------------------------------------------------------------

`timescale 1ns/100ps

`include "fpu_settings.svh"

module tb_fpu_wrap import fpu_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 100 * 20; // About 100 requests at no more than 20 cycles each
    localparam int EW = `FPU_FLEN + `FPU_TAG_BITS + 1; // Expected entry {result, tag, nv}

    logic                     clk_i, rst_ni, flush_i;
    logic                     fpu_valid_i, fpu_ready_o;
    fu_op_e                   fu_op_i;
    logic [2:0]               rm_i;
    logic [`FPU_FLEN-1:0]     operand_a_i, operand_b_i;
    logic [`FPU_TAG_BITS-1:0] trans_id_i, result_tag_o, tag_cnt;
    logic                     result_valid_o, result_ready_i, invalid_o;
    logic [`FPU_FLEN-1:0]     result_o;

    logic [EW-1:0] exp_q[$];             // Pending results, oldest first
    integer        seed = 32'hd0cd_8851;
    int            cyc = 0;              // Rising edges since time zero
    int            checks = 0;
    int            errors = 0;
    int            err0;
    int            accept_cyc, result_cyc; // Edge of last accept and last result

    fpu_wrap fpu_wrap_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin : timeout
        cyc = cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d results outstanding", cyc, exp_q.size());
            $display("sim failed");
            $finish;
        end
    end

    //------------------------------------------------------------------
    // Reference model
    //------------------------------------------------------------------

    // RISC-V class mask with bit 8 for sNaN and bit 9 for qNaN
    function automatic logic [9:0] class_of(input logic [31:0] x);
        logic [7:0]  e;
        logic [22:0] m;
        e = x[30:23];
        m = x[22:0];
        if (e == 8'hff && m != 23'd0)
            return m[22] ? 10'h200 : 10'h100;
        if (e == 8'hff)
            return x[31] ? 10'h001 : 10'h080;
        if (e == 8'h00 && m == 23'd0)
            return x[31] ? 10'h008 : 10'h010;
        if (e == 8'h00)
            return x[31] ? 10'h004 : 10'h020;
        return x[31] ? 10'h002 : 10'h040;
    endfunction

    // Unsigned key in numeric order with -0 just below +0
    function automatic logic [31:0] order_key(input logic [31:0] x);
        return x[31] ? ~x : (x | 32'h8000_0000);
    endfunction

    // Returns {nv, result}
    function automatic logic [32:0] model(input fu_op_e op, input logic [2:0] rm,
                                          input logic [31:0] a, input logic [31:0] b);
        logic [9:0] ca, cb;
        logic       a_nan, b_nan, nv;
        ca    = class_of(a);
        cb    = class_of(b);
        a_nan = ca[9] | ca[8];
        b_nan = cb[9] | cb[8];
        nv    = ca[8] | cb[8];      // Signaling NaN only
        case (op)
            FSGNJ: begin
                if (rm == 3'd0)
                    return {1'b0, b[31], a[30:0]};
                if (rm == 3'd1)
                    return {1'b0, ~b[31], a[30:0]};
                if (rm == 3'd2)
                    return {1'b0, a[31] ^ b[31], a[30:0]};
                return {1'b0, a};   // Other rm copies a
            end
            FMIN_MAX: begin
                if (a_nan && b_nan)
                    return {nv, `FPU_QNAN};
                if (a_nan)
                    return {nv, b};
                if (b_nan)
                    return {nv, a};
                // rm[0] low keeps the smaller key
                if ((order_key(a) < order_key(b)) != rm[0])
                    return {nv, a};
                return {nv, b};
            end
            FCLASS:  return {1'b0, 22'd0, ca};
            default: return {1'b0, a}; // Moves
        endcase
    endfunction

    //------------------------------------------------------------------
    // Driver, monitor and checks
    //------------------------------------------------------------------

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Starts 1 ns after an edge and returns 1 ns after the accepting edge
    task automatic issue(input fu_op_e op, input logic [2:0] rm,
                         input logic [31:0] a, input logic [31:0] b);
        logic [32:0] want;
        want        = model(op, rm, a, b);
        fu_op_i     = op;
        rm_i        = rm;
        operand_a_i = a;
        operand_b_i = b;
        trans_id_i  = tag_cnt;
        fpu_valid_i = 1'b1;
        @(negedge clk_i);
        while (!fpu_ready_o)
            @(negedge clk_i);  // Hold the request until taken
        exp_q.push_back({want[31:0], tag_cnt, want[32]});
        accept_cyc = cyc + 1;
        tag_cnt    = tag_cnt + 1'b1;
        @(posedge clk_i);
        #1;
        fpu_valid_i = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0)
            @(posedge clk_i);
        #1;
    endtask

    always @(negedge clk_i) begin : monitor
        logic [EW-1:0] want;
        if (rst_ni && result_valid_o && result_ready_i) begin
            result_cyc = cyc + 1;  // Transfer on the coming edge
            checks++;
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("Result with tag %h arrived with no request pending", result_tag_o);
            end
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                check_val("result_o", result_o, want[EW-1:`FPU_TAG_BITS+1]);
                check_val("result_tag_o", 32'(result_tag_o), 32'(want[`FPU_TAG_BITS:1]));
                check_val("invalid_o", 32'(invalid_o), 32'(want[0]));
            end
        end
    end

    //------------------------------------------------------------------
    // Directed tests
    //------------------------------------------------------------------

    task automatic sign_injection_test();
        logic [31:0] a, b;
        for (int i = 0; i < 20; i++) begin
            a = $random(seed);
            b = $random(seed);
            for (int rm = 0; rm < 3; rm++)
                issue(FSGNJ, 3'(rm), a, b);
        end
        drain();
    endtask

    task automatic min_max_test();
        logic [31:0] pa [9];
        logic [31:0] pb [9];
        pa = '{32'h3f80_0000, 32'hc040_0000, 32'hc000_0000, 32'h8000_0000, 32'h0000_0000,
               32'h7fc0_0000, 32'h7fc1_2345, 32'h7f80_0001, 32'h3f80_0000};
        pb = '{32'h4000_0000, 32'h3f00_0000, 32'hc080_0000, 32'h0000_0000, 32'h8000_0000,
               32'h4049_0fdb, 32'hffc0_0001, 32'h3f80_0000, 32'hff80_0010};
        for (int i = 0; i < 9; i++) begin
            issue(FMIN_MAX, 3'd0, pa[i], pb[i]); // Min
            issue(FMIN_MAX, 3'd1, pa[i], pb[i]); // Max
        end
        drain();
    endtask

    task automatic class_move_test();
        logic [31:0] vals [10];
        logic [31:0] a, b;
        // One value per class in mask bit order
        vals = '{32'hff80_0000, 32'hbf80_0000, 32'h807f_ffff, 32'h8000_0000, 32'h0000_0000,
                 32'h0000_0001, 32'h3f80_0000, 32'h7f80_0000, 32'h7f80_0001, 32'h7fc0_0000};
        for (int i = 0; i < 10; i++)
            issue(FCLASS, 3'd0, vals[i], 32'h0);
        a = $random(seed);
        b = $random(seed);
        issue(FMV_F2X, 3'd0, a, b);
        issue(FMV_X2F, 3'd0, a, b);
        issue(FSGNJ, 3'd3, a, b);
        drain();
    endtask

    task automatic backpressure_test();
        result_ready_i = 1'b0;
        issue(FSGNJ, 3'd1, 32'h3f80_0000, 32'h0000_0000);  // Into stage 1
        issue(FCLASS, 3'd0, 32'hbf80_0000, 32'h0000_0000); // Both stages full
        // Third request lands in the hold buffer and the issuer sees ready low
        fork
            issue(FMIN_MAX, 3'd1, 32'h4000_0000, 32'hc000_0000);
            begin
                repeat (3) begin
                    @(negedge clk_i);
                    check_val("fpu_ready_o", 32'(fpu_ready_o), 32'h0);
                end
                @(posedge clk_i);
                #1;
                result_ready_i = 1'b1;
            end
        join
        drain();
    endtask

    task automatic latency_flush_test();
        issue(FSGNJ, 3'd2, 32'hc0a0_0000, 32'h8000_0000);
        drain();
        check_val("result latency", 32'(result_cyc - accept_cyc), 32'd2);
        result_ready_i = 1'b0;  // Keep both in flight
        issue(FMV_X2F, 3'd0, 32'h1234_5678, 32'h0);
        issue(FCLASS, 3'd0, 32'h0000_0001, 32'h0);
        // Third request parks in the hold buffer and is never acknowledged
        fu_op_i     = FMV_F2X;
        rm_i        = 3'd0;
        operand_a_i = 32'h4248_0000;
        operand_b_i = 32'h0;
        trans_id_i  = tag_cnt;
        fpu_valid_i = 1'b1;
        @(negedge clk_i);
        check_val("fpu_ready_o", 32'(fpu_ready_o), 32'h0);
        @(posedge clk_i);
        #1;
        fpu_valid_i = 1'b0;     // Issuer withdraws as the flush arrives
        flush_i     = 1'b1;
        @(posedge clk_i);
        #1;
        flush_i = 1'b0;
        exp_q.delete();         // Flushed and held work gives no result
        @(negedge clk_i);
        check_val("result_valid_o", 32'(result_valid_o), 32'h0);
        check_val("fpu_ready_o", 32'(fpu_ready_o), 32'h1);
        @(posedge clk_i);
        #1;
        result_ready_i = 1'b1;
        issue(FMIN_MAX, 3'd0, 32'h8000_0000, 32'h0000_0000);
        issue(FSGNJ, 3'd0, 32'h4120_0000, 32'h8000_0000);
        drain();
    endtask

    task automatic report(input string name, input int err_before);
        $display("test %s: done, %0d errors", name, errors - err_before);
    endtask

    initial begin
        rst_ni         = 1'b0;
        flush_i        = 1'b0;
        fpu_valid_i    = 1'b0;
        result_ready_i = 1'b1;
        fu_op_i        = FSGNJ;
        rm_i           = 3'd0;
        operand_a_i    = '0;
        operand_b_i    = '0;
        trans_id_i     = '0;
        tag_cnt        = '0;
        repeat (4) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        err0 = errors;
        sign_injection_test();
        report("sign injection", err0);
        err0 = errors;
        min_max_test();
        report("min/max", err0);
        err0 = errors;
        class_move_test();
        report("class and move", err0);
        err0 = errors;
        backpressure_test();
        report("back-pressure", err0);
        err0 = errors;
        latency_flush_test();
        report("latency and flush", err0);

        repeat (5) @(posedge clk_i); // Catch stray results
        checks++;
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%0d results never arrived", exp_q.size());
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

//--- bench/fpu_wrap_assert.sv
//----------------------------------------------------------------------
// Concurrent checks on the result side of the FP unit. Bound into the
// top level, so every instance of the unit carries them.
//----------------------------------------------------------------------

`timescale 1ns/100ps

`include "fpu_settings.svh"

module fpu_wrap_assert (
    input logic                     clk_i,
    input logic                     rst_ni,
    input logic                     flush_i,
    input logic                     result_valid_i,
    input logic                     result_ready_i,
    input logic [`FPU_FLEN-1:0]     result_i,
    input logic [`FPU_TAG_BITS-1:0] result_tag_i,
    input logic                     invalid_i
);

    // Stalled result keeps data, tag and flag
    a_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        result_valid_i && !result_ready_i && !flush_i |=>
            $stable(result_i) && $stable(result_tag_i) && $stable(invalid_i))
        else $error("result changed while waiting for ready");

    a_reset: assert property (@(posedge clk_i) !rst_ni |-> !result_valid_i)
        else $error("result valid during reset");

    // Flush empties both stages
    a_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> !result_valid_i)
        else $error("result valid right after flush");

endmodule

bind fpu_wrap fpu_wrap_assert fpu_wrap_assert_i (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .flush_i        ( flush_i        ),
    .result_valid_i ( result_valid_o ),
    .result_ready_i ( result_ready_i ),
    .result_i       ( result_o       ),
    .result_tag_i   ( result_tag_o   ),
    .invalid_i      ( invalid_o      )
);

//--- logic/fpu_wrap.sv
//----------------------------------------------------------------------
// Top level of the scalar FP32 functional unit. Issued requests are
// decoded, pass the protocol-inversion hold buffer and run through the
// two-stage execution pipeline; tagged results leave in issue order.
//----------------------------------------------------------------------

`timescale 1ns/100ps

`include "fpu_settings.svh"

module fpu_wrap import fpu_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     fpu_valid_i,
    output logic                     fpu_ready_o,
    input  fu_op_e                   fu_op_i,
    input  logic [2:0]               rm_i,
    input  logic [`FPU_FLEN-1:0]     operand_a_i,
    input  logic [`FPU_FLEN-1:0]     operand_b_i,
    input  logic [`FPU_TAG_BITS-1:0] trans_id_i,
    output logic                     result_valid_o,
    input  logic                     result_ready_i,
    output logic [`FPU_FLEN-1:0]     result_o,
    output logic [`FPU_TAG_BITS-1:0] result_tag_o,
    output logic                     invalid_o
);

    fpu_op_e  issue_op;
    fpu_req_t issue_req, exec_req;
    logic     exec_valid, exec_ready;

    fpu_decoder fpu_decoder_i (
        .fu_op_i ( fu_op_i  ),
        .rm_i    ( rm_i     ),
        .op_o    ( issue_op )
    );

    assign issue_req = '{operand_a: operand_a_i, operand_b: operand_b_i,
                         op: issue_op, tag: trans_id_i};

    fpu_hold_buffer #(
        .payload_t ( fpu_req_t )
    ) fpu_hold_buffer_i (
        .clk_i   ( clk_i       ),
        .rst_ni  ( rst_ni      ),
        .flush_i ( flush_i     ),
        .valid_i ( fpu_valid_i ),
        .ready_o ( fpu_ready_o ),
        .data_i  ( issue_req   ),
        .valid_o ( exec_valid  ),
        .ready_i ( exec_ready  ),
        .data_o  ( exec_req    )
    );

    fpu_exec_pipe fpu_exec_pipe_i (
        .clk_i       ( clk_i          ),
        .rst_ni      ( rst_ni         ),
        .flush_i     ( flush_i        ),
        .in_valid_i  ( exec_valid     ),
        .in_ready_o  ( exec_ready     ),
        .req_i       ( exec_req       ),
        .out_valid_o ( result_valid_o ),
        .out_ready_i ( result_ready_i ), // Real back-pressure from writeback
        .result_o    ( result_o       ),
        .tag_o       ( result_tag_o   ),
        .invalid_o   ( invalid_o      )
    );

endmodule

//--- logic/fpu_exec_pipe.sv
//----------------------------------------------------------------------
// Two-stage execution pipeline of the FP32 unit. Stage 1 registers the
// request, stage 2 registers the result with its tag and NV flag.
// Handles sign injection, min/max, class and move.
//----------------------------------------------------------------------

`timescale 1ns/100ps

`include "fpu_settings.svh"

module fpu_exec_pipe import fpu_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     in_valid_i,
    output logic                     in_ready_o,
    input  fpu_req_t                 req_i,
    output logic                     out_valid_o,
    input  logic                     out_ready_i,
    output logic [`FPU_FLEN-1:0]     result_o,
    output logic [`FPU_TAG_BITS-1:0] tag_o,
    output logic                     invalid_o
);

    logic                     s1_valid_q, s2_valid_q;
    fpu_req_t                 s1_req_q;
    logic [`FPU_FLEN-1:0]     s2_result_q;
    logic [`FPU_TAG_BITS-1:0] s2_tag_q;
    logic                     s2_nv_q;
    logic                     s1_advance, s2_advance;
    logic [`FPU_FLEN-1:0]     op_a, op_b, result_d;
    logic                     nv_d;
    logic                     a_nan, b_nan, a_snan, b_snan, a_lt_b;
    logic [9:0]               class_mask; // RISC-V FCLASS encoding

    // NaN when exponent all ones and mantissa non-zero
    function automatic logic is_nan(input logic [`FPU_FLEN-1:0] x);
        return (&x[30:23]) && (|x[22:0]);
    endfunction

    //------------------------------------------------------------------
    // Stage handshake
    //------------------------------------------------------------------

    assign s2_advance = !s2_valid_q || out_ready_i;
    assign s1_advance = !s1_valid_q || s2_advance;
    assign in_ready_o = s1_advance;

    assign op_a   = s1_req_q.operand_a;
    assign op_b   = s1_req_q.operand_b;
    assign a_nan  = is_nan(op_a);
    assign b_nan  = is_nan(op_b);
    assign a_snan = a_nan && !op_a[22]; // Quiet bit clear
    assign b_snan = b_nan && !op_b[22];

    // Magnitude order; -0 sorts below +0 via the sign test
    always_comb begin : p_order
        if (op_a[31] != op_b[31])
            a_lt_b = op_a[31];
        else if (op_a[31])
            a_lt_b = op_a[30:0] > op_b[30:0]; // Both negative, larger magnitude is smaller
        else
            a_lt_b = op_a[30:0] < op_b[30:0];
    end

    always_comb begin : p_class
        class_mask = '0;
        if (&op_a[30:23]) begin
            if (~|op_a[22:0])
                class_mask[op_a[31] ? 0 : 7] = 1'b1; // Infinity
            else
                class_mask[op_a[22] ? 9 : 8] = 1'b1; // Quiet or signaling NaN
        end else if (~|op_a[30:23]) begin
            if (~|op_a[22:0])
                class_mask[op_a[31] ? 3 : 4] = 1'b1; // Zero
            else
                class_mask[op_a[31] ? 2 : 5] = 1'b1; // Subnormal
        end else begin
            class_mask[op_a[31] ? 1 : 6] = 1'b1;     // Normal
        end
    end

    always_comb begin : p_result
        result_d = op_a;
        nv_d     = 1'b0;
        case (s1_req_q.op)
            OP_SGNJ:  result_d = {op_b[31], op_a[30:0]};
            OP_SGNJN: result_d = {~op_b[31], op_a[30:0]};
            OP_SGNJX: result_d = {op_a[31] ^ op_b[31], op_a[30:0]};
            OP_MIN,
            OP_MAX: begin
                nv_d = a_snan || b_snan; // Only signaling NaNs raise NV
                if (a_nan && b_nan)
                    result_d = `FPU_QNAN;
                else if (a_nan)
                    result_d = op_b;
                else if (b_nan)
                    result_d = op_a;
                else if ((s1_req_q.op == OP_MIN) == a_lt_b)
                    result_d = op_a;
                else
                    result_d = op_b;
            end
            OP_CLASS: result_d = {{(`FPU_FLEN-10){1'b0}}, class_mask};
            default:  result_d = op_a; // Move
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
        if (!rst_ni) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else if (flush_i) begin
            s1_valid_q <= 1'b0; // Drop everything in flight
            s2_valid_q <= 1'b0;
        end else begin
            if (s1_advance)
                s1_valid_q <= in_valid_i;
            if (s2_advance)
                s2_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin : p_data
        if (s1_advance && in_valid_i)
            s1_req_q <= req_i;
        if (s2_advance && s1_valid_q) begin
            s2_result_q <= result_d;
            s2_tag_q    <= s1_req_q.tag;
            s2_nv_q     <= nv_d;
        end
    end

    assign out_valid_o = s2_valid_q;
    assign result_o    = s2_result_q;
    assign tag_o       = s2_tag_q;
    assign invalid_o   = s2_nv_q;

endmodule

//--- logic/fpu_hold_buffer.sv
//----------------------------------------------------------------------
// Upstream protocol inversion. The issue side sees ready high unless
// a request arrives while the downstream unit is busy; that request is
// captured here and offered downstream until it is taken.
//----------------------------------------------------------------------

`timescale 1ns/100ps

module fpu_hold_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     flush_i,
    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t data_i,
    output logic     valid_o,
    input  logic     ready_i,
    output payload_t data_o
);

    typedef enum logic {READY, STALL} state_e;

    state_e   state_q, state_d;
    logic     hold_inputs;      // Capture data_i this cycle
    logic     use_hold;         // Drive downstream from the hold register
    payload_t hold_q;

    //------------------------------------------------------------------
    // FSM
    //------------------------------------------------------------------

    always_comb begin : p_fsm
        ready_o     = 1'b0;
        valid_o     = 1'b0;
        hold_inputs = 1'b0;
        use_hold    = 1'b0;
        state_d     = state_q;

        case (state_q)
            READY: begin
                ready_o = 1'b1;    // Looks ready to the issuer
                valid_o = valid_i; // Straight through
                // Unit busy, keep the request and block the issuer
                if (valid_i && !ready_i) begin
                    ready_o     = 1'b0;
                    hold_inputs = 1'b1;
                    state_d     = STALL;
                end
            end
            STALL: begin
                valid_o  = 1'b1;
                use_hold = 1'b1;
                if (ready_i) begin   // Held request consumed
                    ready_o = 1'b1;
                    state_d = READY;
                end
            end
            default: state_d = READY;
        endcase

        if (flush_i)
            state_d = READY; // Flush drops any held request
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
        if (!rst_ni)
            state_q <= READY;
        else
            state_q <= state_d;
    end

    always_ff @(posedge clk_i) begin : p_hold_reg
        if (hold_inputs)
            hold_q <= data_i;
    end

    assign data_o = use_hold ? hold_q : data_i;

endmodule

//--- logic/fpu_decoder.sv
//----------------------------------------------------------------------
// Input translation of the FP unit. Maps the issue-side operator and
// its rm field onto one internal operation. Purely combinational.
//----------------------------------------------------------------------

`timescale 1ns/100ps

module fpu_decoder import fpu_pkg::*; (
    input  fu_op_e     fu_op_i,
    input  logic [2:0] rm_i,
    output fpu_op_e    op_o
);

    //------------------------------------------------------------------
    // Operator translation
    //------------------------------------------------------------------

    always_comb begin : p_translate
        op_o = OP_MOVE; // Pass-through unless told otherwise

        case (fu_op_i)
            // Sign injection variant sits in rm (000-010)
            FSGNJ: begin
                case (rm_i)
                    3'b000:  op_o = OP_SGNJ;
                    3'b001:  op_o = OP_SGNJN;
                    3'b010:  op_o = OP_SGNJX;
                    default: op_o = OP_MOVE; // rm 011 and up is a plain copy of a
                endcase
            end

            // Min or max chosen by the lowest rm bit
            FMIN_MAX: begin
                if (rm_i[0])
                    op_o = OP_MAX;
                else
                    op_o = OP_MIN;
            end

            FCLASS: op_o = OP_CLASS; // rm is ignored

            // No recoding for moves, operand a goes straight out
            FMV_F2X,
            FMV_X2F: op_o = OP_MOVE;

            default: op_o = OP_MOVE;
        endcase
    end

endmodule

//--- logic/fpu_pkg.sv
//----------------------------------------------------------------------
// Types shared by the FP functional unit: the issue-side operator,
// the internal operation and the packed request that flows from the
// hold buffer into the execution pipeline.
//----------------------------------------------------------------------

`include "fpu_settings.svh"

package fpu_pkg;

    // Operator as delivered by the issue stage
    typedef enum logic [2:0] {
        FSGNJ,    // Sign injection, variant in rm
        FMIN_MAX, // Min or max, variant in rm[0]
        FCLASS,
        FMV_F2X,  // FP register to integer register
        FMV_X2F   // Integer register to FP register
    } fu_op_e;

    // Operation as executed by the pipeline
    typedef enum logic [2:0] {
        OP_SGNJ,
        OP_SGNJN,
        OP_SGNJX,
        OP_MIN,
        OP_MAX,
        OP_CLASS,
        OP_MOVE   // Operand a passes through
    } fpu_op_e;

    // One issued request, 70 bits
    typedef struct packed {
        logic [`FPU_FLEN-1:0]     operand_a;
        logic [`FPU_FLEN-1:0]     operand_b;
        fpu_op_e                  op;
        logic [`FPU_TAG_BITS-1:0] tag;
    } fpu_req_t;

endpackage

//--- logic/fpu_settings.svh
//----------------------------------------------------------------------
// Global sizes and constants of the scalar FP32 functional unit.
// Include this file wherever the data width, the tag width or the
// canonical NaN is needed.
//----------------------------------------------------------------------

`ifndef FPU_SETTINGS_SVH
`define FPU_SETTINGS_SVH

// Operand and result width, single precision only
`define FPU_FLEN 32

// Width of the transaction id carried alongside each request
`define FPU_TAG_BITS 3

`define FPU_QNAN 32'h7fc0_0000 // Canonical quiet NaN

`endif
